//--- source/core_pkg.sv
`default_nettype none

package core_pkg;

  localparam int word_width      = 64;
  localparam int instr_width     = 32;
  localparam int reg_addr_width  = 5;
  localparam int reg_count       = 32;
  localparam int imem_addr_width = 8;
  localparam int imem_depth      = 256;

  // funct3 codes of the supported subset
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl     = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;
  localparam logic [2:0] f3_addi    = 3'b000;
  localparam logic [2:0] f3_beq     = 3'b000;
  localparam logic [2:0] f3_bne     = 3'b001;
  localparam logic [2:0] f3_priv    = 3'b000;

  // funct7 and funct12 codes
  localparam logic [6:0]  f7_base   = 7'b0000000;
  localparam logic [6:0]  f7_alt    = 7'b0100000;
  localparam logic [11:0] f12_ecall = 12'h000;

  typedef enum logic [6:0] {
    op_alu    = 7'b0110011,
    op_imm    = 7'b0010011,
    op_lui    = 7'b0110111,
    op_branch = 7'b1100011,
    op_jal    = 7'b1101111,
    op_system = 7'b1110011
  } opcode_t;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_sll,
    alu_srl,
    alu_pass_b,
    alu_link
  } alu_op_t;

  typedef enum logic [1:0] {
    br_none,
    br_eq,
    br_ne,
    br_jal
  } branch_kind_t;

endpackage

`default_nettype wire

//--- source/fetch_unit.sv
`default_nettype none

module fetch_unit import core_pkg::*; (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [word_width-1:0]      entry,
  input  logic                       imem_we,
  input  logic [imem_addr_width-1:0] imem_addr,
  input  logic [instr_width-1:0]     imem_wdata,
  input  logic                       redirect,
  input  logic [word_width-1:0]      redirect_pc,
  input  logic                       halt_fetch,
  output logic                       f_valid,
  output logic [word_width-1:0]      f_pc,
  output logic [instr_width-1:0]     f_instr
);

  logic [instr_width-1:0]     imem [imem_depth];
  logic [word_width-1:0]      pc;
  logic [imem_addr_width-1:0] fetch_index;

  // word index, instructions are 4-byte aligned
  assign fetch_index = pc[imem_addr_width+1:2];

  // load port, driven by the testbench while the core is held in reset
  always_ff @(posedge clk) begin
    if (imem_we) begin
      imem[imem_addr] <= imem_wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc      <= entry;
      f_valid <= 1'b0;
    end else if (redirect) begin
      // target is fetched next cycle, this slot becomes a bubble
      pc      <= redirect_pc;
      f_valid <= 1'b0;
    end else if (halt_fetch) begin
      f_valid <= 1'b0;
    end else begin
      pc      <= pc + word_width'(4);
      f_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    f_pc    <= pc;
    f_instr <= imem[fetch_index];
  end

endmodule

`default_nettype wire

//--- source/decode_unit.sv
`default_nettype none

module decode_unit import core_pkg::*; (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      f_valid,
  input  logic [word_width-1:0]     f_pc,
  input  logic [instr_width-1:0]    f_instr,
  input  logic                      squash,
  input  logic                      wb_en,
  input  logic [reg_addr_width-1:0] wb_rd,
  input  logic [word_width-1:0]     wb_value,
  output logic                      d_valid,
  output logic [word_width-1:0]     d_pc,
  output logic [reg_addr_width-1:0] d_rd,
  output logic [reg_addr_width-1:0] d_rs1,
  output logic [reg_addr_width-1:0] d_rs2,
  output logic [word_width-1:0]     d_rs1_value,
  output logic [word_width-1:0]     d_rs2_value,
  output logic [word_width-1:0]     d_imm,
  output logic                      d_use_imm,
  output alu_op_t                   d_alu_op,
  output branch_kind_t              d_branch_kind,
  output logic                      d_is_ecall
);

  logic [word_width-1:0]     regs [reg_count];
  opcode_t                   opcode;
  logic [2:0]                funct3;
  logic [6:0]                funct7;
  logic [reg_addr_width-1:0] rd_field;
  logic [reg_addr_width-1:0] rs1_field;
  logic [reg_addr_width-1:0] rs2_field;
  logic [word_width-1:0]     imm_i;
  logic [word_width-1:0]     imm_b;
  logic [word_width-1:0]     imm_j;
  logic [word_width-1:0]     imm_u;
  logic [word_width-1:0]     rs1_value;
  logic [word_width-1:0]     rs2_value;
  logic [word_width-1:0]     imm;
  logic                      use_imm;
  logic                      writes_rd;
  logic                      is_ecall;
  alu_op_t                   alu_op;
  branch_kind_t              branch_kind;

  assign opcode    = opcode_t'(f_instr[6:0]);
  assign rd_field  = f_instr[11:7];
  assign funct3    = f_instr[14:12];
  assign rs1_field = f_instr[19:15];
  assign rs2_field = f_instr[24:20];
  assign funct7    = f_instr[31:25];

  assign imm_i = {{52{f_instr[31]}}, f_instr[31:20]};
  assign imm_b = {{51{f_instr[31]}}, f_instr[31], f_instr[7], f_instr[30:25],
                  f_instr[11:8], 1'b0};
  assign imm_j = {{43{f_instr[31]}}, f_instr[31], f_instr[19:12], f_instr[20],
                  f_instr[30:21], 1'b0};
  assign imm_u = {{32{f_instr[31]}}, f_instr[31:12], 12'b0};

  // x0 reads as zero, a same-cycle write to the source wins
  assign rs1_value = (rs1_field == '0) ? '0 :
                     (wb_en && wb_rd == rs1_field) ? wb_value : regs[rs1_field];
  assign rs2_value = (rs2_field == '0) ? '0 :
                     (wb_en && wb_rd == rs2_field) ? wb_value : regs[rs2_field];

  always_ff @(posedge clk) begin
    if (wb_en && wb_rd != '0) begin
      regs[wb_rd] <= wb_value;
    end
  end

  // anything not matched below stays a no-op with rd zero
  always_comb begin
    alu_op      = alu_add;
    branch_kind = br_none;
    imm         = '0;
    use_imm     = 1'b0;
    writes_rd   = 1'b0;
    is_ecall    = 1'b0;
    case (opcode)
      op_alu: begin
        if (funct7 == f7_base) begin
          writes_rd = 1'b1;
          case (funct3)
            f3_add_sub: alu_op = alu_add;
            f3_sll:     alu_op = alu_sll;
            f3_slt:     alu_op = alu_slt;
            f3_xor:     alu_op = alu_xor;
            f3_srl:     alu_op = alu_srl;
            f3_or:      alu_op = alu_or;
            f3_and:     alu_op = alu_and;
            default:    writes_rd = 1'b0;
          endcase
        end else if (funct7 == f7_alt && funct3 == f3_add_sub) begin
          writes_rd = 1'b1;
          alu_op    = alu_sub;
        end
      end
      op_imm: begin
        if (funct3 == f3_addi) begin
          writes_rd = 1'b1;
          use_imm   = 1'b1;
          imm       = imm_i;
        end
      end
      op_lui: begin
        writes_rd = 1'b1;
        use_imm   = 1'b1;
        imm       = imm_u;
        alu_op    = alu_pass_b;
      end
      op_branch: begin
        imm = imm_b;
        if (funct3 == f3_beq) begin
          branch_kind = br_eq;
        end else if (funct3 == f3_bne) begin
          branch_kind = br_ne;
        end
      end
      op_jal: begin
        writes_rd   = 1'b1;
        imm         = imm_j;
        alu_op      = alu_link;
        branch_kind = br_jal;
      end
      op_system: begin
        is_ecall = (funct3 == f3_priv) && (f_instr[31:20] == f12_ecall) &&
                   (rs1_field == '0) && (rd_field == '0);
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      d_valid <= 1'b0;
    end else begin
      d_valid <= f_valid && !squash;
    end
  end

  always_ff @(posedge clk) begin
    d_pc          <= f_pc;
    d_rd          <= writes_rd ? rd_field : '0;
    d_rs1         <= rs1_field;
    d_rs2         <= rs2_field;
    d_rs1_value   <= rs1_value;
    d_rs2_value   <= rs2_value;
    d_imm         <= imm;
    d_use_imm     <= use_imm;
    d_alu_op      <= alu_op;
    d_branch_kind <= branch_kind;
    d_is_ecall    <= is_ecall;
  end

endmodule

`default_nettype wire

//--- source/execute_unit.sv
`default_nettype none

module execute_unit import core_pkg::*; (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      d_valid,
  input  logic [word_width-1:0]     d_pc,
  input  logic [reg_addr_width-1:0] d_rd,
  input  logic [reg_addr_width-1:0] d_rs1,
  input  logic [reg_addr_width-1:0] d_rs2,
  input  logic [word_width-1:0]     d_rs1_value,
  input  logic [word_width-1:0]     d_rs2_value,
  input  logic [word_width-1:0]     d_imm,
  input  logic                      d_use_imm,
  input  alu_op_t                   d_alu_op,
  input  branch_kind_t              d_branch_kind,
  input  logic                      d_is_ecall,
  input  logic                      fwd_valid,
  input  logic [reg_addr_width-1:0] fwd_rd,
  input  logic [word_width-1:0]     fwd_value,
  output logic                      redirect,
  output logic [word_width-1:0]     redirect_pc,
  output logic                      squash,
  output logic                      e_valid,
  output logic [word_width-1:0]     e_pc,
  output logic [reg_addr_width-1:0] e_rd,
  output logic [word_width-1:0]     e_value,
  output logic                      e_is_ecall
);

  logic [word_width-1:0]     op_a;
  logic [word_width-1:0]     rs2_fwd;
  logic [word_width-1:0]     op_b;
  logic [word_width-1:0]     alu_result;
  logic [reg_addr_width-1:0] rd_eff;
  logic                      taken;
  logic                      ecall_now;
  logic                      halt_pending;

  // the instruction one ahead sits in the result stage
  assign op_a    = (fwd_valid && fwd_rd != '0 && fwd_rd == d_rs1) ? fwd_value : d_rs1_value;
  assign rs2_fwd = (fwd_valid && fwd_rd != '0 && fwd_rd == d_rs2) ? fwd_value : d_rs2_value;
  assign op_b    = d_use_imm ? d_imm : rs2_fwd;

  always_comb begin
    case (d_alu_op)
      alu_add:    alu_result = op_a + op_b;
      alu_sub:    alu_result = op_a - op_b;
      alu_and:    alu_result = op_a & op_b;
      alu_or:     alu_result = op_a | op_b;
      alu_xor:    alu_result = op_a ^ op_b;
      alu_slt:    alu_result = {{(word_width-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      alu_sll:    alu_result = op_a << op_b[5:0];
      alu_srl:    alu_result = op_a >> op_b[5:0];
      alu_pass_b: alu_result = op_b;
      alu_link:   alu_result = d_pc + word_width'(4);
      default:    alu_result = '0;
    endcase
  end

  always_comb begin
    case (d_branch_kind)
      br_eq:   taken = (op_a == rs2_fwd);
      br_ne:   taken = (op_a != rs2_fwd);
      br_jal:  taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  assign redirect    = d_valid && taken;
  assign redirect_pc = d_pc + d_imm;
  assign ecall_now   = d_valid && d_is_ecall;

  // once an ecall has passed, nothing younger may proceed
  assign squash = redirect || ecall_now || halt_pending;

  // branches and ecall never write a register
  assign rd_eff = (d_branch_kind == br_eq || d_branch_kind == br_ne || d_is_ecall) ?
                  '0 : d_rd;

  always_ff @(posedge clk) begin
    if (reset) begin
      halt_pending <= 1'b0;
      e_valid      <= 1'b0;
    end else begin
      if (ecall_now) begin
        halt_pending <= 1'b1;
      end
      e_valid <= d_valid && !halt_pending;
    end
  end

  always_ff @(posedge clk) begin
    e_pc       <= d_pc;
    e_rd       <= rd_eff;
    e_value    <= (rd_eff == '0) ? '0 : alu_result;
    e_is_ecall <= d_is_ecall;
  end

endmodule

`default_nettype wire

//--- source/result_unit.sv
`default_nettype none

module result_unit import core_pkg::*; (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      e_valid,
  input  logic [word_width-1:0]     e_pc,
  input  logic [reg_addr_width-1:0] e_rd,
  input  logic [word_width-1:0]     e_value,
  input  logic                      e_is_ecall,
  output logic                      wb_en,
  output logic [reg_addr_width-1:0] wb_rd,
  output logic [word_width-1:0]     wb_value,
  output logic                      retire_valid,
  output logic [word_width-1:0]     retire_pc,
  output logic [reg_addr_width-1:0] retire_rd,
  output logic [word_width-1:0]     retire_value,
  output logic                      halted
);

  // register-file write and forward source, straight from the execute register
  assign wb_en    = e_valid && (e_rd != '0) && !halted;
  assign wb_rd    = e_rd;
  assign wb_value = e_value;

  always_ff @(posedge clk) begin
    if (reset) begin
      retire_valid <= 1'b0;
      halted       <= 1'b0;
    end else begin
      retire_valid <= e_valid && !halted;
      if (e_valid && e_is_ecall) begin
        halted <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    retire_pc    <= e_pc;
    retire_rd    <= e_rd;
    retire_value <= e_value;
  end

endmodule

`default_nettype wire

//--- source/core_top.sv
`default_nettype none

module core_top import core_pkg::*; (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [word_width-1:0]      entry,
  input  logic                       imem_we,
  input  logic [imem_addr_width-1:0] imem_addr,
  input  logic [instr_width-1:0]     imem_wdata,
  output logic                       retire_valid,
  output logic [word_width-1:0]      retire_pc,
  output logic [reg_addr_width-1:0]  retire_rd,
  output logic [word_width-1:0]      retire_value,
  output logic                       halted
);

  logic                      f_valid;
  logic [word_width-1:0]     f_pc;
  logic [instr_width-1:0]    f_instr;
  logic                      d_valid;
  logic [word_width-1:0]     d_pc;
  logic [reg_addr_width-1:0] d_rd;
  logic [reg_addr_width-1:0] d_rs1;
  logic [reg_addr_width-1:0] d_rs2;
  logic [word_width-1:0]     d_rs1_value;
  logic [word_width-1:0]     d_rs2_value;
  logic [word_width-1:0]     d_imm;
  logic                      d_use_imm;
  alu_op_t                   d_alu_op;
  branch_kind_t              d_branch_kind;
  logic                      d_is_ecall;
  logic                      redirect;
  logic [word_width-1:0]     redirect_pc;
  logic                      squash;
  logic                      e_valid;
  logic [word_width-1:0]     e_pc;
  logic [reg_addr_width-1:0] e_rd;
  logic [word_width-1:0]     e_value;
  logic                      e_is_ecall;
  logic                      wb_en;
  logic [reg_addr_width-1:0] wb_rd;
  logic [word_width-1:0]     wb_value;

  fetch_unit fetch0 (
    .clk         (clk),
    .reset       (reset),
    .entry       (entry),
    .imem_we     (imem_we),
    .imem_addr   (imem_addr),
    .imem_wdata  (imem_wdata),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .halt_fetch  (halted),
    .f_valid     (f_valid),
    .f_pc        (f_pc),
    .f_instr     (f_instr)
  );

  decode_unit decode0 (
    .clk           (clk),
    .reset         (reset),
    .f_valid       (f_valid),
    .f_pc          (f_pc),
    .f_instr       (f_instr),
    .squash        (squash),
    .wb_en         (wb_en),
    .wb_rd         (wb_rd),
    .wb_value      (wb_value),
    .d_valid       (d_valid),
    .d_pc          (d_pc),
    .d_rd          (d_rd),
    .d_rs1         (d_rs1),
    .d_rs2         (d_rs2),
    .d_rs1_value   (d_rs1_value),
    .d_rs2_value   (d_rs2_value),
    .d_imm         (d_imm),
    .d_use_imm     (d_use_imm),
    .d_alu_op      (d_alu_op),
    .d_branch_kind (d_branch_kind),
    .d_is_ecall    (d_is_ecall)
  );

  // forwarding taps the result stage write port
  execute_unit execute0 (
    .clk           (clk),
    .reset         (reset),
    .d_valid       (d_valid),
    .d_pc          (d_pc),
    .d_rd          (d_rd),
    .d_rs1         (d_rs1),
    .d_rs2         (d_rs2),
    .d_rs1_value   (d_rs1_value),
    .d_rs2_value   (d_rs2_value),
    .d_imm         (d_imm),
    .d_use_imm     (d_use_imm),
    .d_alu_op      (d_alu_op),
    .d_branch_kind (d_branch_kind),
    .d_is_ecall    (d_is_ecall),
    .fwd_valid     (wb_en),
    .fwd_rd        (wb_rd),
    .fwd_value     (wb_value),
    .redirect      (redirect),
    .redirect_pc   (redirect_pc),
    .squash        (squash),
    .e_valid       (e_valid),
    .e_pc          (e_pc),
    .e_rd          (e_rd),
    .e_value       (e_value),
    .e_is_ecall    (e_is_ecall)
  );

  result_unit result0 (
    .clk          (clk),
    .reset        (reset),
    .e_valid      (e_valid),
    .e_pc         (e_pc),
    .e_rd         (e_rd),
    .e_value      (e_value),
    .e_is_ecall   (e_is_ecall),
    .wb_en        (wb_en),
    .wb_rd        (wb_rd),
    .wb_value     (wb_value),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_value (retire_value),
    .halted       (halted)
  );

endmodule

`default_nettype wire

//--- tb/clock_gen.sv
`default_nettype none

module clock_gen (
  output logic clk
);

  // period 20, first rising edge at time 10
  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

endmodule

`default_nettype wire

//--- tb/core_tb.sv
`default_nettype none

module core_tb;

  // {funct7, funct3} of the register-register operations
  localparam logic [9:0] fn_add = 10'h000;
  localparam logic [9:0] fn_sub = 10'h100;
  localparam logic [9:0] fn_sll = 10'h001;
  localparam logic [9:0] fn_slt = 10'h002;
  localparam logic [9:0] fn_xor = 10'h004;
  localparam logic [9:0] fn_srl = 10'h005;
  localparam logic [9:0] fn_or  = 10'h006;
  localparam logic [9:0] fn_and = 10'h007;
  localparam logic [9:0] fn_table [8] = '{fn_add, fn_sub, fn_and, fn_or,
                                          fn_xor, fn_slt, fn_sll, fn_srl};
  localparam logic [31:0] ecall_word = 32'h0000_0073;

  logic        clk;
  logic        reset;
  logic [63:0] entry;
  logic        imem_we;
  logic [7:0]  imem_addr;
  logic [31:0] imem_wdata;
  logic        retire_valid;
  logic [63:0] retire_pc;
  logic [4:0]  retire_rd;
  logic [63:0] retire_value;
  logic        halted;

  // reference model state
  logic [31:0] model_mem [256];
  logic [63:0] model_regs [32];
  logic [63:0] model_pc;

  logic [31:0] prog [$];
  logic [63:0] exp_pc [$];
  logic [63:0] ret_pc [$];
  logic [63:0] ret_rd [$];
  logic [63:0] ret_val [$];

  string test_name;
  int    seed = 68029;
  int    cycle = 0;
  int    errors = 0;
  int    checks = 0;
  int    tests = 0;
  int    err_mark = 0;

  clock_gen clock0 (
    .clk (clk)
  );

  core_top dut0 (
    .clk          (clk),
    .reset        (reset),
    .entry        (entry),
    .imem_we      (imem_we),
    .imem_addr    (imem_addr),
    .imem_wdata   (imem_wdata),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_value (retire_value),
    .halted       (halted)
  );

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  function automatic logic [31:0] r_op(input logic [9:0] code, input logic [4:0] rd,
                                       input logic [4:0] rs1, input logic [4:0] rs2);
    return {code[9:3], rs2, rs1, code[2:0], rd, 7'h33};
  endfunction

  function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'h13};
  endfunction

  function automatic logic [31:0] lui(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, 7'h37};
  endfunction

  function automatic logic [31:0] branch(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
  endfunction

  function automatic logic [31:0] jal(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
  endfunction

  // one of x1 to x7
  function automatic logic [4:0] pick_reg(input logic [7:0] v);
    return 5'(v % 8'd7) + 5'd1;
  endfunction

  task automatic check_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    assert (actual === expected) else begin
      $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, expected, actual);
      errors++;
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    err_mark  = errors;
    prog.delete();
  endtask

  task automatic finish_test();
    tests++;
    $display("%s: %0d retires, %0d errors", test_name, ret_pc.size(), errors - err_mark);
  endtask

  // executes one instruction of the ISA subset and reports what should retire
  task automatic model_step(output logic [63:0] pc, output logic [63:0] rd,
                            output logic [63:0] value, output bit taken, output bit stop);
    logic [31:0] ins;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] res;
    logic [63:0] next_pc;
    bit          writes;
    ins     = model_mem[model_pc[9:2]];
    a       = model_regs[ins[19:15]];
    b       = model_regs[ins[24:20]];
    res     = '0;
    writes  = 1'b0;
    taken   = 1'b0;
    stop    = 1'b0;
    next_pc = model_pc + 64'd4;
    case (ins[6:0])
      7'h33: begin
        writes = 1'b1;
        case ({ins[31:25], ins[14:12]})
          fn_add:  res = a + b;
          fn_sub:  res = a - b;
          fn_and:  res = a & b;
          fn_or:   res = a | b;
          fn_xor:  res = a ^ b;
          fn_slt:  res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
          fn_sll:  res = a << b[5:0];
          fn_srl:  res = a >> b[5:0];
          default: writes = 1'b0;
        endcase
      end
      7'h13: begin
        writes = (ins[14:12] == 3'b000);
        res    = a + 64'($signed(ins[31:20]));
      end
      7'h37: begin
        writes = 1'b1;
        res    = 64'($signed({ins[31:12], 12'h000}));
      end
      7'h63: begin
        if (ins[14:12] == 3'b000) begin
          taken = (a == b);
        end else if (ins[14:12] == 3'b001) begin
          taken = (a != b);
        end
        if (taken) begin
          next_pc = model_pc + 64'($signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}));
        end
      end
      7'h6f: begin
        writes  = 1'b1;
        res     = model_pc + 64'd4;
        taken   = 1'b1;
        next_pc = model_pc + 64'($signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}));
      end
      7'h73: begin
        stop = (ins == ecall_word);
      end
      default: begin
      end
    endcase
    if (!writes || ins[11:7] == 5'd0) begin
      rd    = '0;
      value = '0;
    end else begin
      rd    = 64'(ins[11:7]);
      value = res;
      model_regs[ins[11:7]] = res;
    end
    pc       = model_pc;
    model_pc = next_pc;
  endtask

  // fills all of instruction memory in reset
  // unused words hold no-ops tagged with their index
  task automatic load_and_start(input logic [63:0] entry_pc);
    int          i;
    int          base;
    logic [31:0] word;
    base = int'(entry_pc[9:2]);
    @(posedge clk);
    reset <= 1'b1;
    entry <= entry_pc;
    repeat (3) @(posedge clk);
    for (i = 0; i < 256; i++) begin
      if (i >= base && i - base < prog.size()) begin
        word = prog[i - base];
      end else begin
        word = addi(5'd0, 5'd0, 12'(i));
      end
      model_mem[i] = word;
      @(posedge clk);
      imem_we    <= 1'b1;
      imem_addr  <= 8'(i);
      imem_wdata <= word;
    end
    @(posedge clk);
    imem_we <= 1'b0;
    reset   <= 1'b0;
  endtask

  task automatic wait_retire(input int limit, output bit seen);
    int n;
    seen = 1'b0;
    n    = 0;
    while (!seen && n < limit) begin
      @(negedge clk);
      seen = retire_valid;
      n++;
    end
  endtask

  task automatic run_program(input logic [63:0] entry_pc, input int quiet);
    logic [63:0] pc;
    logic [63:0] rd;
    logic [63:0] value;
    bit          taken;
    bit          stop;
    bit          seen;
    bit          prev_taken;
    int          prev_cycle;
    int          n;
    int          i;
    exp_pc.delete();
    ret_pc.delete();
    ret_rd.delete();
    ret_val.delete();
    load_and_start(entry_pc);
    for (i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    model_pc = entry_pc;
    @(negedge clk);
    check_value("halted after reset", 64'd0, 64'(halted));
    stop       = 1'b0;
    seen       = 1'b1;
    prev_taken = 1'b0;
    prev_cycle = 0;
    n          = 0;
    while (!stop && n < 300) begin
      model_step(pc, rd, value, taken, stop);
      exp_pc.push_back(pc);
      wait_retire(12, seen);
      assert (seen) else begin
        $display("%s: no retire pulse within 12 cycles, expected pc %h", test_name, pc);
        errors++;
      end
      if (!seen) begin
        break;
      end
      ret_pc.push_back(retire_pc);
      ret_rd.push_back(64'(retire_rd));
      ret_val.push_back(retire_value);
      check_value("pc", pc, retire_pc);
      check_value("rd", rd, 64'(retire_rd));
      check_value("value", value, retire_value);
      check_value("halted", 64'(stop), 64'(halted));
      // a taken branch or jump costs two squashed slots
      if (n > 0) begin
        check_value("retire gap", prev_taken ? 64'd3 : 64'd1, 64'(cycle - prev_cycle));
      end
      prev_taken = taken;
      prev_cycle = cycle;
      n++;
    end
    assert (!seen || stop) else begin
      $display("%s: program did not reach its ecall", test_name);
      errors++;
    end
    if (stop && seen) begin
      for (i = 0; i < quiet; i++) begin
        @(negedge clk);
        assert (!retire_valid && halted) else begin
          $display("%s: retire pulse or halted drop after the ecall", test_name);
          errors++;
        end
      end
    end
  endtask

  task automatic alu_chain_test();
    int i;
    start_test("alu_chain");
    prog.push_back(addi(5'd1, 5'd0, 12'h123));
    prog.push_back(lui(5'd2, 20'h12345));
    prog.push_back(r_op(fn_add, 5'd3, 5'd1, 5'd2));
    prog.push_back(r_op(fn_sub, 5'd4, 5'd3, 5'd1));
    prog.push_back(r_op(fn_and, 5'd5, 5'd4, 5'd3));
    prog.push_back(r_op(fn_or, 5'd6, 5'd5, 5'd1));
    prog.push_back(r_op(fn_xor, 5'd7, 5'd6, 5'd4));
    prog.push_back(r_op(fn_slt, 5'd8, 5'd7, 5'd1));
    prog.push_back(addi(5'd9, 5'd0, 12'd4));
    prog.push_back(r_op(fn_sll, 5'd10, 5'd7, 5'd9));
    prog.push_back(r_op(fn_srl, 5'd11, 5'd10, 5'd9));
    prog.push_back(r_op(fn_sub, 5'd12, 5'd1, 5'd2));
    prog.push_back(r_op(fn_slt, 5'd13, 5'd12, 5'd1));
    prog.push_back(r_op(fn_srl, 5'd14, 5'd12, 5'd9));
    prog.push_back(ecall_word);
    run_program(64'h0, 6);
    check_value("retire count", 64'(prog.size()), 64'(ret_pc.size()));
    // straight-line code from address zero
    for (i = 0; i < ret_pc.size(); i++) begin
      check_value("sequential pc", 64'(4 * i), ret_pc[i]);
    end
    finish_test();
  endtask

  task automatic imm_x0_test();
    start_test("imm_x0");
    prog.push_back(addi(5'd1, 5'd0, 12'hfff));
    prog.push_back(addi(5'd2, 5'd0, 12'h800));
    prog.push_back(lui(5'd3, 20'h80000));
    prog.push_back(lui(5'd4, 20'hfffff));
    prog.push_back(addi(5'd0, 5'd1, 12'h005));
    prog.push_back(r_op(fn_add, 5'd5, 5'd0, 5'd1));
    prog.push_back(r_op(fn_add, 5'd0, 5'd3, 5'd4));
    prog.push_back(r_op(fn_or, 5'd6, 5'd0, 5'd0));
    prog.push_back(addi(5'd7, 5'd3, 12'hfff));
    prog.push_back(addi(5'd8, 5'd0, 12'h7ff));
    prog.push_back(ecall_word);
    // program placed away from address zero
    run_program(64'h100, 6);
    if (ret_val.size() >= 3) begin
      check_value("addi -2048", 64'hffff_ffff_ffff_f800, ret_val[1]);
      check_value("lui sign", 64'hffff_ffff_8000_0000, ret_val[2]);
    end
    finish_test();
  endtask

  task automatic branch_test();
    int i;
    start_test("branches");
    prog.push_back(addi(5'd1, 5'd0, 12'd7));
    prog.push_back(addi(5'd2, 5'd0, 12'd7));
    prog.push_back(branch(3'b000, 5'd1, 5'd2, 13'd12));
    prog.push_back(addi(5'd3, 5'd0, 12'd1));
    prog.push_back(addi(5'd3, 5'd0, 12'd2));
    prog.push_back(branch(3'b001, 5'd1, 5'd2, 13'd12));
    prog.push_back(addi(5'd4, 5'd0, 12'd3));
    prog.push_back(addi(5'd2, 5'd2, 12'd1));
    prog.push_back(branch(3'b001, 5'd1, 5'd2, 13'd12));
    prog.push_back(addi(5'd5, 5'd0, 12'd1));
    prog.push_back(addi(5'd5, 5'd0, 12'd2));
    prog.push_back(branch(3'b000, 5'd1, 5'd2, 13'd8));
    prog.push_back(addi(5'd6, 5'd0, 12'd9));
    prog.push_back(ecall_word);
    run_program(64'h0, 6);
    // the two slots behind each taken branch
    for (i = 0; i < ret_pc.size(); i++) begin
      assert (ret_pc[i] != 64'd12 && ret_pc[i] != 64'd16 &&
              ret_pc[i] != 64'd36 && ret_pc[i] != 64'd40) else begin
        $display("%s: squashed instruction at pc %h retired", test_name, ret_pc[i]);
        errors++;
      end
    end
    finish_test();
  endtask

  task automatic jal_loop_test();
    int i;
    int dut_hits;
    int model_hits;
    start_test("jal_loop");
    prog.push_back(addi(5'd1, 5'd0, 12'd5));
    prog.push_back(addi(5'd2, 5'd0, 12'd0));
    prog.push_back(addi(5'd1, 5'd1, 12'hfff));
    prog.push_back(addi(5'd2, 5'd2, 12'd3));
    prog.push_back(branch(3'b001, 5'd1, 5'd0, 13'h1ff8));
    prog.push_back(jal(5'd5, 21'd12));
    prog.push_back(addi(5'd6, 5'd0, 12'd1));
    prog.push_back(addi(5'd6, 5'd0, 12'd2));
    prog.push_back(r_op(fn_add, 5'd7, 5'd5, 5'd2));
    prog.push_back(jal(5'd0, 21'd8));
    prog.push_back(addi(5'd7, 5'd0, 12'd0));
    prog.push_back(ecall_word);
    run_program(64'h0, 6);
    dut_hits   = 0;
    model_hits = 0;
    for (i = 0; i < ret_pc.size(); i++) begin
      if (ret_pc[i] == 64'd8) begin
        dut_hits++;
      end
      // the jal sits at pc 20 and links to 24
      if (ret_pc[i] == 64'd20) begin
        check_value("jal rd", 64'd5, ret_rd[i]);
        check_value("jal link", 64'd24, ret_val[i]);
      end
    end
    for (i = 0; i < exp_pc.size(); i++) begin
      if (exp_pc[i] == 64'd8) begin
        model_hits++;
      end
    end
    check_value("loop iterations", 64'(model_hits), 64'(dut_hits));
    finish_test();
  endtask

  task automatic ecall_halt_test();
    start_test("ecall_halt");
    prog.push_back(addi(5'd1, 5'd0, 12'd11));
    prog.push_back(addi(5'd2, 5'd1, 12'd1));
    prog.push_back(ecall_word);
    prog.push_back(addi(5'd3, 5'd0, 12'd1));
    prog.push_back(addi(5'd4, 5'd0, 12'd2));
    prog.push_back(r_op(fn_add, 5'd5, 5'd1, 5'd2));
    prog.push_back(jal(5'd0, 21'h1fffe8));
    run_program(64'h0, 30);
    if (ret_pc.size() > 0) begin
      check_value("last pc", 64'd8, ret_pc[ret_pc.size()-1]);
    end
    finish_test();
  endtask

  task automatic random_alu_test();
    int          i;
    int          r;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    start_test("random_alu");
    for (i = 1; i <= 7; i++) begin
      r = $random(seed);
      prog.push_back(addi(5'(i), 5'd0, r[11:0]));
    end
    for (i = 0; i < 40; i++) begin
      r   = $random(seed);
      rd  = pick_reg(r[7:0]);
      rs1 = pick_reg(r[15:8]);
      rs2 = pick_reg(r[23:16]);
      if (r[27:26] == 2'b11) begin
        prog.push_back(addi(rd, rs1, r[31:20]));
      end else begin
        prog.push_back(r_op(fn_table[r[30:28]], rd, rs1, rs2));
      end
    end
    prog.push_back(ecall_word);
    run_program(64'h0, 6);
    finish_test();
  endtask

  initial begin
    reset      = 1'b1;
    entry      = '0;
    imem_we    = 1'b0;
    imem_addr  = '0;
    imem_wdata = '0;
    alu_chain_test();
    imm_x0_test();
    branch_test();
    jal_loop_test();
    ecall_halt_test();
    random_alu_test();
    $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
source/core_pkg.sv
source/fetch_unit.sv
source/decode_unit.sv
source/execute_unit.sv
source/result_unit.sv
source/core_top.sv
tb/clock_gen.sv
tb/core_tb.sv

//--- Makefile
SOURCES := $(shell cat filelist.f)

obj_dir/Vcore_tb: filelist.f $(SOURCES)
	verilator --binary --timing --assert --top-module core_tb -f filelist.f

run: obj_dir/Vcore_tb
	@out="$$(obj_dir/Vcore_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

.PHONY: run clean
